//--- flist.f
source/leaf_pkg.sv
source/stream_fifo.sv
source/leaf_rx_demux.sv
source/leaf_tx_arbiter.sv
source/leaf_interface.sv
source/user_kernel.sv
source/leaf_i3o4.sv
testbench/tb_leaf_i3o4.sv

//--- testbench/tb_leaf_i3o4.sv
module tb_leaf_i3o4;

    localparam int DEPTH     = leaf_pkg::FIFO_DEPTH;
    localparam int NOUT      = leaf_pkg::NUM_OUT_PORTS;
    localparam int EXP_SLOTS = 256;

    logic              clk;
    logic              rst_n;
    logic              ap_start;
    logic              resend;
    leaf_pkg::packet_t din;
    leaf_pkg::packet_t dout;

    leaf_pkg::packet_t exp_mem [NOUT][EXP_SLOTS];   // one expected queue per kernel output.
    int                wr_cnt [NOUT] = '{default: 0};
    int                rd_cnt [NOUT] = '{default: 0};
    leaf_pkg::word_t   in1_pend [$];
    leaf_pkg::word_t   in2_pend [$];
    leaf_pkg::word_t   run_sum;
    leaf_pkg::packet_t exp_pkt;
    logic              exp_known;
    logic              started;
    int                seed;
    int                sent;
    int                mismatches = 0;
    int                other_errors = 0;

    leaf_i3o4 dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .ap_start (ap_start),
        .resend   (resend),
        .din      (din),
        .dout     (dout)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic leaf_pkg::word_t rand_word();
        return $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic route_match(input leaf_pkg::packet_t p, input int k);
        return p.leaf == leaf_pkg::DEST_TABLE[k].leaf && p.port == leaf_pkg::DEST_TABLE[k].port;
    endfunction

    function automatic int pending_count();
        int total;
        total = 0;
        for (int k = 0; k < NOUT; k++) begin
            total += wr_cnt[k] - rd_cnt[k];
        end
        return total;
    endfunction

    // ======================================================================
    // expected model and checks
    // ======================================================================
    task automatic push_expected(input int k, input leaf_pkg::word_t data);
        leaf_pkg::packet_t p;
        p.vld     = 1'b1;
        p.leaf    = leaf_pkg::DEST_TABLE[k].leaf;
        p.port    = leaf_pkg::DEST_TABLE[k].port;
        p.tag     = {leaf_pkg::THIS_LEAF, 2'(k)};   // sender leaf and output port minus one.
        p.payload = data;
        exp_mem[k][wr_cnt[k] % EXP_SLOTS] = p;
        wr_cnt[k]++;
    endtask

    always_comb begin
        exp_known = 1'b0;
        exp_pkt   = '0;
        for (int k = 0; k < NOUT; k++) begin
            if (route_match(dout, k) && rd_cnt[k] != wr_cnt[k]) begin
                exp_known = 1'b1;
                exp_pkt   = exp_mem[k][rd_cnt[k] % EXP_SLOTS];
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && dout.vld) begin
            for (int k = 0; k < NOUT; k++) begin
                if (route_match(dout, k) && rd_cnt[k] != wr_cnt[k]) begin
                    rd_cnt[k] <= rd_cnt[k] + 1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) dout.vld |-> exp_known)
        else begin
            other_errors++;
            $display("unexpected packet on dout for leaf %0d port %0d",
                     $sampled(dout.leaf), $sampled(dout.port));
        end

    assert property (@(posedge clk) disable iff (!rst_n) dout.vld && exp_known |-> dout == exp_pkt)
        else begin
            mismatches++;
            $display("MISMATCH dout: expected %h, got %h", $sampled(exp_pkt), $sampled(dout));
        end

    // nothing may leave before the kernel has been started.
    assert property (@(posedge clk) disable iff (!rst_n) !started |-> dout == '0)
        else begin
            mismatches++;
            $display("MISMATCH dout before ap_start: expected 0, got %h", $sampled(dout));
        end

    assert property (@(posedge clk) disable iff (!rst_n) resend |-> dout == '0)
        else begin
            mismatches++;
            $display("MISMATCH dout during resend: expected 0, got %h", $sampled(dout));
        end

    // ======================================================================
    // stimulus
    // ======================================================================
    task automatic drive_packet(input logic vld, input logic [4:0] leaf, input logic [3:0] port,
                                input leaf_pkg::word_t data);
        din.vld     = vld;
        din.leaf    = leaf;
        din.port    = port;
        din.tag     = '0;
        din.payload = data;
        sent++;
        @(negedge clk);
        din = '0;
    endtask

    task automatic send_word(input int port, input leaf_pkg::word_t data);
        leaf_pkg::word_t a;
        leaf_pkg::word_t b;
        if (port == 1) begin
            in1_pend.push_back(data);
        end else if (port == 2) begin
            in2_pend.push_back(data);
        end else begin
            run_sum += data;
            push_expected(1, data);
            push_expected(2, run_sum);
        end
        while (in1_pend.size() != 0 && in2_pend.size() != 0) begin
            a = in1_pend.pop_front();
            b = in2_pend.pop_front();
            push_expected(0, a + b);
            push_expected(3, (a > b) ? a : b);
        end
        drive_packet(1'b1, leaf_pkg::THIS_LEAF, 4'(port), data);
    endtask

    // packets the leaf must ignore.
    task automatic send_noise(input int kind);
        if (kind == 0) begin
            drive_packet(1'b0, leaf_pkg::THIS_LEAF, 4'd1, rand_word());
        end else if (kind == 1) begin
            drive_packet(1'b1, leaf_pkg::THIS_LEAF ^ 5'(1 + rand_below(31)), 4'd2, rand_word());
        end else if (kind == 2) begin
            drive_packet(1'b1, leaf_pkg::THIS_LEAF, 4'd0, rand_word());
        end else begin
            drive_packet(1'b1, leaf_pkg::THIS_LEAF, 4'(4 + rand_below(12)), rand_word());
        end
    endtask

    task automatic wait_drain();
        while (pending_count() != 0) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);   // room for a stray extra packet to show.
    endtask

    initial begin
        int cycles;
        cycles = 0;
        while (cycles <= 20 * sent + 2000) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: expected packets not all received");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int kind;
        int pairs;
        int singles;
        seed     = 32'h38bbc1b2;
        sent     = 0;
        run_sum  = '0;
        rst_n    = 1'b0;
        ap_start = 1'b0;
        resend   = 1'b0;
        started  = 1'b0;
        din      = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // words on all three ports wait in the receive FIFOs while the kernel is held.
        for (int i = 0; i < 6; i++) begin
            send_word(1, rand_word());
        end
        for (int i = 0; i < 4; i++) begin
            send_word(2, rand_word());
            send_word(3, rand_word());
        end
        for (int i = 0; i < 4; i++) begin
            send_noise(i);
        end
        repeat (30) @(negedge clk);
        ap_start = 1'b1;
        started  = 1'b1;
        @(negedge clk);
        ap_start = 1'b0;
        for (int i = 0; i < 2; i++) begin
            send_word(2, rand_word());
        end
        wait_drain();

        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < DEPTH; i++) begin
                send_word(1, rand_word());
                send_word(2, rand_word());
            end
            wait_drain();
        end
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < DEPTH; i++) begin
                send_word(3, rand_word());
            end
            wait_drain();
        end

        // mixed traffic with filtered packets in between.
        pairs   = 0;
        singles = 0;
        for (int i = 0; i < 30; i++) begin
            kind = rand_below(6);
            if (kind == 0 && pairs < DEPTH) begin
                send_word(1, rand_word());
                send_word(2, rand_word());
                pairs++;
            end else if (kind == 1 && singles < DEPTH) begin
                send_word(3, rand_word());
                singles++;
            end else if (kind >= 2) begin
                send_noise(kind - 2);
            end
        end
        wait_drain();

        for (int i = 0; i < DEPTH; i++) begin
            send_word(1, rand_word());
            send_word(2, rand_word());
            send_word(3, rand_word());
            if (i == 2) begin
                resend = 1'b1;
            end
        end
        repeat (40) @(negedge clk);
        resend = 1'b0;
        wait_drain();

        $display("errors: %0d mismatches, %0d other, %0d expected packets missing",
                 mismatches, other_errors, pending_count());
        if (mismatches == 0 && other_errors == 0 && pending_count() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- source/leaf_i3o4.sv
module leaf_i3o4 (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ap_start,
    input  logic              resend,
    input  leaf_pkg::packet_t din,
    output leaf_pkg::packet_t dout
);
    leaf_pkg::stream_t [leaf_pkg::NUM_IN_PORTS-1:0]  to_user;
    logic [leaf_pkg::NUM_IN_PORTS-1:0]               ack_from_user;
    leaf_pkg::stream_t [leaf_pkg::NUM_OUT_PORTS-1:0] from_user;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0]              ack_to_user;
    logic                                            kernel_rst_n;

    leaf_interface leaf_interface_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .ap_start      (ap_start),
        .resend        (resend),
        .din           (din),
        .dout          (dout),
        .to_user       (to_user),
        .ack_from_user (ack_from_user),
        .from_user     (from_user),
        .ack_to_user   (ack_to_user),
        .kernel_rst_n  (kernel_rst_n)
    );

    user_kernel user_kernel_inst (
        .clk          (clk),
        .kernel_rst_n (kernel_rst_n),
        .in_s         (to_user),
        .in_ack       (ack_from_user),
        .out_s        (from_user),
        .out_ack      (ack_to_user)
    );

endmodule

//--- source/user_kernel.sv
module user_kernel (
    input  logic                                          clk,
    input  logic                                          kernel_rst_n,
    input  leaf_pkg::stream_t [leaf_pkg::NUM_IN_PORTS-1:0]  in_s,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]             in_ack,
    output leaf_pkg::stream_t [leaf_pkg::NUM_OUT_PORTS-1:0] out_s,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]            out_ack
);
    // index k here is kernel port k+1.
    leaf_pkg::word_t                    out_data [leaf_pkg::NUM_OUT_PORTS];
    logic [leaf_pkg::NUM_OUT_PORTS-1:0] out_vld;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0] slot_free;
    leaf_pkg::word_t                    run_sum;
    leaf_pkg::word_t                    next_sum;
    leaf_pkg::word_t                    pair_sum;
    leaf_pkg::word_t                    pair_max;
    logic                               pair_go;
    logic                               strm_go;

    // empty, or emptied this cycle, and never while the kernel is held in reset.
    assign slot_free = kernel_rst_n ? (~out_vld | out_ack) : '0;

    // ======================================================================
    // pair unit on in 1 and in 2
    // ======================================================================
    assign pair_go  = in_s[0].vld && in_s[1].vld && slot_free[0] && slot_free[3];
    assign pair_sum = in_s[0].data + in_s[1].data;   // wraps at 32 bits.
    assign pair_max = (in_s[0].data > in_s[1].data) ? in_s[0].data : in_s[1].data;

    // stream unit on in 3.
    assign strm_go  = in_s[2].vld && slot_free[1] && slot_free[2];
    assign next_sum = run_sum + in_s[2].data;

    assign in_ack = {strm_go, pair_go, pair_go};

    always_ff @(posedge clk) begin
        if (!kernel_rst_n) begin
            out_vld <= '0;
            run_sum <= '0;
        end else begin
            out_vld <= out_vld & ~out_ack;
            if (pair_go) begin
                out_vld[0] <= 1'b1;
                out_vld[3] <= 1'b1;
            end
            if (strm_go) begin
                out_vld[1] <= 1'b1;
                out_vld[2] <= 1'b1;
                run_sum    <= next_sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pair_go) begin
            out_data[0] <= pair_sum;
            out_data[3] <= pair_max;
        end
        if (strm_go) begin
            out_data[1] <= in_s[2].data;
            out_data[2] <= next_sum;
        end
    end

    always_comb begin
        for (int k = 0; k < leaf_pkg::NUM_OUT_PORTS; k++) begin
            out_s[k].data = out_data[k];
            out_s[k].vld  = out_vld[k];
        end
    end

    // an offered input word stays put until the kernel takes it.
    for (genvar k = 0; k < leaf_pkg::NUM_IN_PORTS; k++) begin : g_hold
        assert property (@(posedge clk) disable iff (!kernel_rst_n)
            in_s[k].vld && !in_ack[k] |=> in_s[k].vld && $stable(in_s[k].data));
    end

endmodule

//--- source/leaf_interface.sv
module leaf_interface (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          ap_start,
    input  logic                                          resend,
    input  leaf_pkg::packet_t                             din,
    output leaf_pkg::packet_t                             dout,
    output leaf_pkg::stream_t [leaf_pkg::NUM_IN_PORTS-1:0]  to_user,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0]             ack_from_user,
    input  leaf_pkg::stream_t [leaf_pkg::NUM_OUT_PORTS-1:0] from_user,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]            ack_to_user,
    output logic                                          kernel_rst_n
);
    localparam int SRC_BITS = leaf_pkg::NUM_ADDR_BITS - leaf_pkg::NUM_LEAF_BITS;

    leaf_pkg::word_t                                rx_wr_data;
    logic [leaf_pkg::NUM_IN_PORTS-1:0]              rx_wr_en;
    logic [leaf_pkg::NUM_IN_PORTS-1:0]              rx_full;
    logic [leaf_pkg::NUM_IN_PORTS-1:0]              rx_vld;
    leaf_pkg::word_t                                rx_data [leaf_pkg::NUM_IN_PORTS];
    leaf_pkg::tx_word_t [leaf_pkg::NUM_OUT_PORTS-1:0] tx_wr_data;
    leaf_pkg::tx_word_t [leaf_pkg::NUM_OUT_PORTS-1:0] tx_head;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0]             tx_full;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0]             tx_head_vld;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0]             tx_pop;
    logic                                           started;

    // ======================================================================
    // receive side
    // ======================================================================
    leaf_rx_demux leaf_rx_demux_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .din     (din),
        .wr_data (rx_wr_data),
        .wr_en   (rx_wr_en),
        .full    (rx_full)
    );

    for (genvar i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin : g_rx
        stream_fifo #(.payload_t(leaf_pkg::word_t)) rx_fifo_inst (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_data (rx_wr_data),
            .wr_en   (rx_wr_en[i]),
            .full    (rx_full[i]),
            .rd_data (rx_data[i]),
            .rd_vld  (rx_vld[i]),
            .rd_en   (ack_from_user[i])
        );
    end

    always_comb begin
        for (int i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin
            to_user[i].data = rx_data[i];
            to_user[i].vld  = rx_vld[i];
        end
    end

    // ======================================================================
    // send side
    // ======================================================================
    always_comb begin
        for (int i = 0; i < leaf_pkg::NUM_OUT_PORTS; i++) begin
            tx_wr_data[i].dest_leaf = leaf_pkg::DEST_TABLE[i].leaf;
            tx_wr_data[i].dest_port = leaf_pkg::DEST_TABLE[i].port;
            tx_wr_data[i].src_port  = SRC_BITS'(i);
            tx_wr_data[i].payload   = from_user[i].data;
            ack_to_user[i]          = from_user[i].vld && !tx_full[i];
        end
    end

    for (genvar i = 0; i < leaf_pkg::NUM_OUT_PORTS; i++) begin : g_tx
        stream_fifo #(.payload_t(leaf_pkg::tx_word_t)) tx_fifo_inst (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_data (tx_wr_data[i]),
            .wr_en   (ack_to_user[i]),   // the word moves on vld and ack.
            .full    (tx_full[i]),
            .rd_data (tx_head[i]),
            .rd_vld  (tx_head_vld[i]),
            .rd_en   (tx_pop[i])
        );
    end

    leaf_tx_arbiter leaf_tx_arbiter_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .head     (tx_head),
        .head_vld (tx_head_vld),
        .pop      (tx_pop),
        .resend   (resend),
        .dout     (dout)
    );

    // the kernel leaves reset once ap_start has been seen.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            started <= 1'b0;
        end else if (ap_start) begin
            started <= 1'b1;
        end
    end

    assign kernel_rst_n = started;

endmodule

//--- source/leaf_tx_arbiter.sv
module leaf_tx_arbiter (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  leaf_pkg::tx_word_t [leaf_pkg::NUM_OUT_PORTS-1:0] head,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]             head_vld,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]             pop,
    input  logic                                           resend,
    output leaf_pkg::packet_t                              dout
);
    localparam int SEL_BITS = $clog2(leaf_pkg::NUM_OUT_PORTS);

    logic [SEL_BITS-1:0]                last;
    logic [SEL_BITS-1:0]                win;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0] grant;
    logic                               found;
    int                                 idx;
    leaf_pkg::packet_t                  pkt;
    leaf_pkg::packet_t                  dout_q;

    // ======================================================================
    // round-robin pick, starting after the last winner
    // ======================================================================
    always_comb begin
        found = 1'b0;
        win   = last;
        idx   = 0;
        for (int i = 1; i <= leaf_pkg::NUM_OUT_PORTS; i++) begin
            idx = (int'(last) + i) % leaf_pkg::NUM_OUT_PORTS;
            if (!found && head_vld[idx]) begin
                found = 1'b1;
                win   = SEL_BITS'(idx);
            end
        end
        grant      = '0;
        grant[win] = found;
    end

    always_comb begin
        pkt.vld     = 1'b1;
        pkt.leaf    = head[win].dest_leaf;
        pkt.port    = head[win].dest_port;
        pkt.tag     = {leaf_pkg::THIS_LEAF, head[win].src_port};
        pkt.payload = head[win].payload;
    end

    assign pop = resend ? '0 : grant;

    // ======================================================================
    // output register
    // ======================================================================
    // a packet masked by resend is held and goes out once resend falls.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout_q <= '0;
            last   <= SEL_BITS'(leaf_pkg::NUM_OUT_PORTS - 1);   // out 1 wins first.
        end else if (!resend) begin
            dout_q <= found ? pkt : '0;
            if (found) begin
                last <= win;
            end
        end
    end

    assign dout = resend ? '0 : dout_q;

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(pop));

endmodule

//--- source/leaf_rx_demux.sv
module leaf_rx_demux (
    input  logic                              clk,
    input  logic                              rst_n,
    input  leaf_pkg::packet_t                 din,
    output leaf_pkg::word_t                   wr_data,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0] wr_en,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0] full
);
    leaf_pkg::packet_t                 pkt_q;
    logic                              addr_ok;
    logic [leaf_pkg::NUM_IN_PORTS-1:0] hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_q <= '0;
        end else begin
            pkt_q <= din;
        end
    end

    assign addr_ok = pkt_q.vld && (pkt_q.leaf == leaf_pkg::THIS_LEAF);

    // ports are numbered from 1, so port 0 and 4 to 15 match nothing.
    always_comb begin
        for (int i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin
            hit[i] = addr_ok && (int'(pkt_q.port) == i + 1);
        end
    end

    assign wr_en   = hit & ~full;   // a packet for a full FIFO is dropped.
    assign wr_data = pkt_q.payload;

    // the tree must never send more than a receive FIFO can hold.
    assert property (@(posedge clk) disable iff (!rst_n) (hit & full) == '0);

endmodule

//--- source/stream_fifo.sv
module stream_fifo #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t wr_data,
    input  logic     wr_en,
    output logic     full,
    output payload_t rd_data,
    output logic     rd_vld,
    input  logic     rd_en
);
    localparam int PTR_BITS = $clog2(leaf_pkg::FIFO_DEPTH);

    payload_t            mem [leaf_pkg::FIFO_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                do_wr;
    logic                do_rd;

    assign full    = (count == leaf_pkg::FIFO_DEPTH);
    assign rd_vld  = (count != 0);
    assign rd_data = mem[rd_ptr];   // head is visible without a read.

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && rd_vld;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, so it wraps.
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + do_wr - do_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // writers are expected to honour full.
    assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full);

    // readers only take a word that is presented.
    assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> rd_vld);

endmodule

//--- source/leaf_pkg.sv
package leaf_pkg;

    // ======================================================================
    // widths and sizes
    // ======================================================================
    localparam int PACKET_BITS   = 49;
    localparam int PAYLOAD_BITS  = 32;
    localparam int NUM_LEAF_BITS = 5;
    localparam int NUM_PORT_BITS = 4;
    localparam int NUM_ADDR_BITS = 7;   // sender leaf plus sender port.
    localparam int NUM_IN_PORTS  = 3;
    localparam int NUM_OUT_PORTS = 4;
    localparam int FIFO_DEPTH    = 8;

    localparam logic [NUM_LEAF_BITS-1:0] THIS_LEAF = 5'd3;

    // ======================================================================
    // types
    // ======================================================================
    typedef logic [PAYLOAD_BITS-1:0] word_t;

    typedef struct packed {
        logic                     vld;
        logic [NUM_LEAF_BITS-1:0] leaf;
        logic [NUM_PORT_BITS-1:0] port;
        logic [NUM_ADDR_BITS-1:0] tag;
        word_t                    payload;
    } packet_t;

    typedef struct packed {
        logic [NUM_LEAF_BITS-1:0] leaf;
        logic [NUM_PORT_BITS-1:0] port;
    } dest_t;

    typedef struct packed {
        logic [NUM_LEAF_BITS-1:0]               dest_leaf;
        logic [NUM_PORT_BITS-1:0]               dest_port;
        logic [NUM_ADDR_BITS-NUM_LEAF_BITS-1:0] src_port;   // output port minus one.
        word_t                                  payload;
    } tx_word_t;

    typedef struct packed {
        word_t data;
        logic  vld;
    } stream_t;

    // routing of the kernel outputs, entry 0 is out 1.
    localparam dest_t DEST_TABLE [NUM_OUT_PORTS] = '{
        '{leaf: 5'd1, port: 4'd1},
        '{leaf: 5'd2, port: 4'd2},
        '{leaf: 5'd6, port: 4'd1},
        '{leaf: 5'd1, port: 4'd3}
    };

endpackage
